// File: Makefile
# Verilator simulation of the game display controller

VERILATOR ?= verilator
TOP       ?= tb_game_display
LOG       ?= sim.log
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, grep $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) LOG=$(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^ALL CHECKS PASSED$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
rtl/game_pkg.sv
rtl/color_led.sv
rtl/score_glyph.sv
rtl/seg_scan.sv
rtl/lcd_msg_rom.sv
rtl/lcd_sequencer.sv
rtl/game_display_top.sv
tb/tb_game_display.sv

// File: rtl/color_led.sv
module color_led
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  color_t    p1_color,
    input  color_t    p2_color,
    output led_pair_t leds
);

    led_pair_t next_leds;
    logic      load;

    function automatic rgb_t to_rgb(color_t c);
        rgb_t rgb;
        rgb = '0;
        case (c)
            COLOR_RED:   rgb.r = 1'b1;
            COLOR_GREEN: rgb.g = 1'b1;
            COLOR_BLUE:  rgb.b = 1'b1;
            default:     rgb = '0;
        endcase
        return rgb;
    endfunction

    always_comb begin
        next_leds = '0;
        load      = 1'b0;
        if (p1_color != COLOR_NONE && p2_color == COLOR_NONE) begin
            next_leds.p1 = to_rgb(p1_color);
            load         = 1'b1;
        end else if (p1_color == COLOR_NONE && p2_color != COLOR_NONE) begin
            next_leds.p2 = to_rgb(p2_color);
            load         = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            leds <= '0;
        end else if (load) begin  // Both or neither set holds last value
            leds <= next_leds;
        end
    end

endmodule

// File: rtl/game_display_top.sv
module game_display_top
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  color_t     p1_color,
    input  color_t     p2_color,
    input  score_t     p1_score,
    input  score_t     p2_score,
    input  winner_t    winner,
    output led_pair_t  leds,
    output glyph_t     seg_data,
    output digit_pos_t seg_pos,
    output lcd_bus_t   lcd
);

    glyph_t    p1_glyph;
    glyph_t    p2_glyph;
    logic      rom_line;
    lcd_col_t  rom_column;
    lcd_char_t rom_char;

    color_led u_color_led (
        .clk      (clk),
        .resetn   (resetn),
        .p1_color (p1_color),
        .p2_color (p2_color),
        .leds     (leds)
    );

    score_glyph u_p1_glyph (
        .clk    (clk),
        .resetn (resetn),
        .score  (p1_score),
        .glyph  (p1_glyph)
    );

    score_glyph u_p2_glyph (
        .clk    (clk),
        .resetn (resetn),
        .score  (p2_score),
        .glyph  (p2_glyph)
    );

    seg_scan u_seg_scan (
        .clk      (clk),
        .resetn   (resetn),
        .p1_glyph (p1_glyph),
        .p2_glyph (p2_glyph),
        .seg_data (seg_data),
        .seg_pos  (seg_pos)
    );

    lcd_sequencer u_lcd_sequencer (
        .clk        (clk),
        .resetn     (resetn),
        .rom_char   (rom_char),
        .rom_line   (rom_line),
        .rom_column (rom_column),
        .lcd        (lcd)
    );

    lcd_msg_rom u_lcd_msg_rom (
        .winner   (winner),     // Read live, no register
        .line     (rom_line),
        .column   (rom_column),
        .char_out (rom_char)
    );

endmodule

// File: rtl/game_pkg.sv
package game_pkg;

    typedef logic [1:0] color_t;
    typedef logic [2:0] score_t;
    typedef logic [6:0] glyph_t;      // Segments a..g, a in MSB
    typedef logic [7:0] digit_pos_t;  // One-hot digit enable
    typedef logic [7:0] lcd_char_t;
    typedef logic [1:0] winner_t;
    typedef logic [4:0] lcd_col_t;
    typedef logic [8:0] interval_t;   // Wide enough for HOME_LAST
    typedef logic [2:0] scan_cnt_t;

    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } rgb_t;

    typedef struct packed {
        rgb_t p1;
        rgb_t p2;
    } led_pair_t;

    typedef struct packed {
        logic      e;
        logic      rs;
        logic      rw;
        lcd_char_t data;
    } lcd_bus_t;

    typedef enum logic [2:0] {
        POWER_WAIT,
        FUNC_SET,
        ENTRY_MODE,
        DISP_ON,
        LINE1,
        LINE2,
        RETURN_HOME,
        CLEAR
    } lcd_state_t;

    localparam color_t COLOR_NONE  = 2'd0;
    localparam color_t COLOR_RED   = 2'd1;
    localparam color_t COLOR_GREEN = 2'd2;
    localparam color_t COLOR_BLUE  = 2'd3;

    localparam winner_t WIN_P1 = 2'd1;
    localparam winner_t WIN_P2 = 2'd2;

    // Interval counts, each state lasts LAST + 1 cycles
    localparam interval_t POWER_WAIT_LAST = 9'd70;
    localparam interval_t CMD_LAST        = 9'd30;
    localparam interval_t LINE_LAST       = 9'd20;
    localparam interval_t HOME_LAST       = 9'd400;
    localparam interval_t CLEAR_LAST      = 9'd200;

    localparam lcd_char_t LCD_FUNC       = 8'h3C;  // 8-bit, 2 lines, 5x11
    localparam lcd_char_t LCD_ENTRY      = 8'h06;
    localparam lcd_char_t LCD_DISP       = 8'h0C;  // Display on, no cursor
    localparam lcd_char_t LCD_LINE1_ADDR = 8'h80;
    localparam lcd_char_t LCD_LINE2_ADDR = 8'hC0;
    localparam lcd_char_t LCD_HOME       = 8'h02;
    localparam lcd_char_t LCD_CLEAR      = 8'h01;
    localparam lcd_char_t LCD_SPACE      = 8'h20;
    localparam lcd_char_t LCD_HEART      = 8'h9D;

    localparam lcd_bus_t LCD_BUS_IDLE = '{e: 1'b0, rs: 1'b1, rw: 1'b1, data: 8'h00};

    localparam glyph_t GLYPH_1 = 7'b0110000;
    localparam glyph_t GLYPH_2 = 7'b1101101;
    localparam glyph_t GLYPH_3 = 7'b1111001;
    localparam glyph_t GLYPH_4 = 7'b0110011;
    localparam glyph_t GLYPH_5 = 7'b1011011;
    localparam glyph_t GLYPH_0 = 7'b1111110;

    localparam scan_cnt_t SCAN_P1_DIGIT = 3'd0;
    localparam scan_cnt_t SCAN_P2_DIGIT = 3'd7;

endpackage

// File: rtl/lcd_msg_rom.sv
module lcd_msg_rom
    import game_pkg::*;
(
    input  winner_t   winner,
    input  logic      line,
    input  lcd_col_t  column,
    output lcd_char_t char_out
);

    logic      has_winner;
    lcd_char_t player_digit;

    assign has_winner   = (winner == WIN_P1) || (winner == WIN_P2);
    assign player_digit = (winner == WIN_P1) ? "1" : "2";

    always_comb begin
        char_out = LCD_SPACE;       // Blank banner and columns past 8
        if (has_winner) begin
            if (!line) begin
                // " P1 Win  "
                case (column)
                    5'd1:    char_out = "P";
                    5'd2:    char_out = player_digit;
                    5'd4:    char_out = "W";
                    5'd5:    char_out = "i";
                    5'd6:    char_out = "n";
                    default: char_out = LCD_SPACE;
                endcase
            end else begin
                case (column)       // Two groups of three hearts
                    5'd1,
                    5'd2,
                    5'd3,
                    5'd5,
                    5'd6,
                    5'd7:    char_out = LCD_HEART;
                    default: char_out = LCD_SPACE;
                endcase
            end
        end
    end

endmodule

// File: rtl/lcd_sequencer.sv
module lcd_sequencer
    import game_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  lcd_char_t rom_char,
    output logic      rom_line,
    output lcd_col_t  rom_column,
    output lcd_bus_t  lcd
);

    lcd_state_t state;
    lcd_state_t state_next;
    interval_t  interval;
    interval_t  interval_last;
    lcd_bus_t   bus_next;

    function automatic lcd_bus_t lcd_cmd(lcd_char_t code);
        return '{e: 1'b1, rs: 1'b0, rw: 1'b0, data: code};
    endfunction

    always_comb begin
        case (state)
            POWER_WAIT:  interval_last = POWER_WAIT_LAST;
            LINE1,
            LINE2:       interval_last = LINE_LAST;
            RETURN_HOME: interval_last = HOME_LAST;
            CLEAR:       interval_last = CLEAR_LAST;
            default:     interval_last = CMD_LAST;  // Init commands
        endcase
    end

    always_comb begin
        case (state)
            POWER_WAIT:  state_next = FUNC_SET;
            FUNC_SET:    state_next = ENTRY_MODE;
            ENTRY_MODE:  state_next = DISP_ON;
            DISP_ON:     state_next = LINE1;
            LINE1:       state_next = LINE2;
            LINE2:       state_next = RETURN_HOME;
            RETURN_HOME: state_next = CLEAR;
            CLEAR:       state_next = LINE1;    // Refresh loop
            default:     state_next = POWER_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= POWER_WAIT;
            interval <= '0;
        end else if (interval == interval_last) begin
            state    <= state_next;
            interval <= '0;
        end else begin
            interval <= interval + 1'b1;
        end
    end

    // Interval 0 carries the address, characters follow one column behind
    assign rom_line   = (state == LINE2);
    assign rom_column = lcd_col_t'(interval - 1'b1);

    always_comb begin
        case (state)
            FUNC_SET:    bus_next = lcd_cmd(LCD_FUNC);
            ENTRY_MODE:  bus_next = lcd_cmd(LCD_ENTRY);
            DISP_ON:     bus_next = lcd_cmd(LCD_DISP);
            RETURN_HOME: bus_next = lcd_cmd(LCD_HOME);
            CLEAR:       bus_next = lcd_cmd(LCD_CLEAR);
            LINE1,
            LINE2: begin
                if (interval == '0) begin
                    bus_next = lcd_cmd(rom_line ? LCD_LINE2_ADDR : LCD_LINE1_ADDR);
                end else begin
                    bus_next = '{e: 1'b1, rs: 1'b1, rw: 1'b0, data: rom_char};
                end
            end
            default:     bus_next = LCD_BUS_IDLE;   // Power-up wait
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lcd <= LCD_BUS_IDLE;
        end else begin
            lcd <= bus_next;
        end
    end

endmodule

// File: rtl/score_glyph.sv
module score_glyph
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  score_t score,
    output glyph_t glyph
);

    glyph_t lookup;

    // Score codes count from 1, overflow codes show 0
    always_comb begin
        case (score)
            3'd0:    lookup = GLYPH_1;
            3'd1:    lookup = GLYPH_2;
            3'd2:    lookup = GLYPH_3;
            3'd3:    lookup = GLYPH_4;
            3'd4:    lookup = GLYPH_5;
            default: lookup = GLYPH_0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            glyph <= '0;
        end else begin
            glyph <= lookup;
        end
    end

endmodule

// File: rtl/seg_scan.sv
module seg_scan
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  glyph_t     p1_glyph,
    input  glyph_t     p2_glyph,
    output glyph_t     seg_data,
    output digit_pos_t seg_pos
);

    scan_cnt_t  count;
    glyph_t     next_data;
    digit_pos_t next_pos;

    // Count value doubles as the digit index
    always_comb begin
        next_data = '0;
        next_pos  = '0;
        if (count == SCAN_P1_DIGIT) begin
            next_data               = p1_glyph;
            next_pos[SCAN_P1_DIGIT] = 1'b1;
        end else if (count == SCAN_P2_DIGIT) begin
            next_data               = p2_glyph;
            next_pos[SCAN_P2_DIGIT] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;  // Wraps every 8 cycles
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            seg_data <= '0;
            seg_pos  <= '0;
        end else begin
            seg_data <= next_data;
            seg_pos  <= next_pos;   // Other six digits stay blank
        end
    end

endmodule

// File: tb/tb_game_display.sv
module tb_game_display
    import game_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 20;
    localparam int INIT_CYCLES = int'(POWER_WAIT_LAST) + 1 + 3 * (int'(CMD_LAST) + 1);
    localparam int LOOP_CYCLES = 2 * (int'(LINE_LAST) + 1) + int'(HOME_LAST) + 1
                               + int'(CLEAR_LAST) + 1;
    localparam int RUN_CYCLES  = 3 + INIT_CYCLES + 3 * LOOP_CYCLES + 8;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 300;  // About 2400 cycles

    logic       clk;
    logic       resetn;
    color_t     p1_color;
    color_t     p2_color;
    score_t     p1_score;
    score_t     p2_score;
    winner_t    winner;
    led_pair_t  leds;
    glyph_t     seg_data;
    digit_pos_t seg_pos;
    lcd_bus_t   lcd;

    integer     seed;
    logic       check_en;
    int         led_errors;
    int         seg_errors;
    int         lcd_errors;
    int         other_errors;
    int         total_errors;

    led_pair_t  exp_leds;
    glyph_t     glyph1_q;
    glyph_t     glyph2_q;
    logic [2:0] scan_count;
    glyph_t     exp_seg_data;
    digit_pos_t exp_seg_pos;
    lcd_state_t m_state;
    lcd_state_t out_state;
    int         m_interval;
    lcd_bus_t   exp_lcd;

    game_display_top u_game_display_top (
        .clk      (clk),
        .resetn   (resetn),
        .p1_color (p1_color),
        .p2_color (p2_color),
        .p1_score (p1_score),
        .p2_score (p2_score),
        .winner   (winner),
        .leds     (leds),
        .seg_data (seg_data),
        .seg_pos  (seg_pos),
        .lcd      (lcd)
    );

    function automatic rgb_t colour_bits(color_t c);
        rgb_t rgb;
        rgb = '{r: c == 2'd1, g: c == 2'd2, b: c == 2'd3};
        return rgb;
    endfunction

    // Codes 0..4 show digits 1..5, the rest show 0
    function automatic glyph_t glyph_for(score_t code);
        int digit;
        digit = (code < 3'd5) ? int'(code) + 1 : 0;
        case (digit)
            1:       return GLYPH_1;
            2:       return GLYPH_2;
            3:       return GLYPH_3;
            4:       return GLYPH_4;
            5:       return GLYPH_5;
            default: return GLYPH_0;
        endcase
    endfunction

    function automatic lcd_char_t expected_char(winner_t w, logic second_line, int col);
        string text;
        if ((w != 2'd1 && w != 2'd2) || col > 8) return LCD_SPACE;
        if (!second_line) begin
            text = (w == 2'd1) ? " P1 Win  " : " P2 Win  ";
            return lcd_char_t'(text[col]);
        end
        return (col == 0 || col == 4 || col == 8) ? LCD_SPACE : LCD_HEART;
    endfunction

    function automatic int state_last(lcd_state_t s);
        case (s)
            POWER_WAIT:   return int'(POWER_WAIT_LAST);
            LINE1, LINE2: return int'(LINE_LAST);
            RETURN_HOME:  return int'(HOME_LAST);
            CLEAR:        return int'(CLEAR_LAST);
            default:      return int'(CMD_LAST);
        endcase
    endfunction

    function automatic lcd_state_t state_after(lcd_state_t s);
        case (s)
            POWER_WAIT:  return FUNC_SET;
            FUNC_SET:    return ENTRY_MODE;
            ENTRY_MODE:  return DISP_ON;
            RETURN_HOME: return CLEAR;
            LINE1:       return LINE2;
            LINE2:       return RETURN_HOME;
            default:     return LINE1;  // DISP_ON and CLEAR both lead to line 1
        endcase
    endfunction

    function automatic lcd_bus_t bus_for(lcd_state_t s, int iv, winner_t w);
        lcd_bus_t b;
        b = '{e: 1'b1, rs: 1'b0, rw: 1'b0, data: 8'h00};
        case (s)
            POWER_WAIT:  b = '{e: 1'b0, rs: 1'b1, rw: 1'b1, data: 8'h00};
            FUNC_SET:    b.data = LCD_FUNC;
            ENTRY_MODE:  b.data = LCD_ENTRY;
            DISP_ON:     b.data = LCD_DISP;
            RETURN_HOME: b.data = LCD_HOME;
            CLEAR:       b.data = LCD_CLEAR;
            default: begin
                if (iv == 0) begin
                    b.data = (s == LINE1) ? LCD_LINE1_ADDR : LCD_LINE2_ADDR;
                end else begin
                    b.rs   = 1'b1;
                    b.data = expected_char(w, s == LINE2, iv - 1);
                end
            end
        endcase
        return b;
    endfunction

    function automatic string lcd_test_name(lcd_state_t s);
        if (s == LINE1 || s == LINE2) return "lcd_text";
        if (s == RETURN_HOME || s == CLEAR) return "refresh_loop";
        return "lcd_init";
    endfunction

    task automatic run_cycles(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            p1_color <= color_t'($random(seed));
            p2_color <= color_t'($random(seed));
            if (i % 3 == 0) begin  // Scores change more slowly than colours
                p1_score <= score_t'($random(seed));
                p2_score <= score_t'($random(seed));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Checks start once the first reset edge has loaded the registers
    initial check_en = 1'b0;
    always @(negedge clk) check_en <= 1'b1;

    // Reference model, one register stage per DUT register
    always @(posedge clk) begin
        if (!resetn) begin
            exp_leds <= '0;
        end else if ((p1_color != 2'd0) != (p2_color != 2'd0)) begin
            exp_leds <= '{p1: colour_bits(p1_color), p2: colour_bits(p2_color)};
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            glyph1_q     <= '0;
            glyph2_q     <= '0;
            scan_count   <= 3'd0;
            exp_seg_data <= '0;
            exp_seg_pos  <= '0;
        end else begin
            glyph1_q     <= glyph_for(p1_score);
            glyph2_q     <= glyph_for(p2_score);
            scan_count   <= scan_count + 3'd1;
            exp_seg_data <= (scan_count == 3'd0) ? glyph1_q :
                            (scan_count == 3'd7) ? glyph2_q : 7'd0;
            exp_seg_pos  <= (scan_count == 3'd0) ? 8'b0000_0001 :
                            (scan_count == 3'd7) ? 8'b1000_0000 : 8'd0;
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            m_state    <= POWER_WAIT;
            out_state  <= POWER_WAIT;
            m_interval <= 0;
            exp_lcd    <= '{e: 1'b0, rs: 1'b1, rw: 1'b1, data: 8'h00};
        end else begin
            exp_lcd   <= bus_for(m_state, m_interval, winner);
            out_state <= m_state;
            if (m_interval == state_last(m_state)) begin
                m_state    <= state_after(m_state);
                m_interval <= 0;
            end else begin
                m_interval <= m_interval + 1;
            end
        end
    end

    a_leds: assert property (@(posedge clk) disable iff (!check_en) leds == exp_leds)
        else begin
            led_errors++;
            $display("ERROR color_decode expected %b actual %b", $sampled(exp_leds),
                     $sampled(leds));
        end

    a_seg_data: assert property (@(posedge clk) disable iff (!check_en)
                                 seg_data == exp_seg_data)
        else begin
            seg_errors++;
            $display("ERROR score_scan seg_data expected %b actual %b",
                     $sampled(exp_seg_data), $sampled(seg_data));
        end

    a_seg_pos: assert property (@(posedge clk) disable iff (!check_en) seg_pos == exp_seg_pos)
        else begin
            seg_errors++;
            $display("ERROR score_scan seg_pos expected %b actual %b",
                     $sampled(exp_seg_pos), $sampled(seg_pos));
        end

    a_seg_onehot: assert property (@(posedge clk) disable iff (!check_en) $onehot0(seg_pos))
        else begin
            other_errors++;
            $display("More than one digit is enabled at once, seg_pos is %b",
                     $sampled(seg_pos));
        end

    a_lcd: assert property (@(posedge clk) disable iff (!check_en) lcd == exp_lcd)
        else begin
            lcd_errors++;
            $display("ERROR %s expected %h actual %h", lcd_test_name($sampled(out_state)),
                     $sampled(exp_lcd), $sampled(lcd));
        end

    a_lcd_write: assert property (@(posedge clk) disable iff (!check_en) !lcd.e || !lcd.rw)
        else begin
            other_errors++;
            $display("The LCD was enabled while rw was high");
        end

    initial begin
        seed       = 32'h19f9_beab;
        led_errors = 0;
        seg_errors = 0;
        lcd_errors = 0;
        other_errors = 0;
        resetn     = 1'b0;
        p1_color   = 2'd0;
        p2_color   = 2'd0;
        p1_score   = 3'd0;
        p2_score   = 3'd0;
        winner     = 2'd0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        run_cycles(INIT_CYCLES);
        winner <= 2'd1;
        run_cycles(LOOP_CYCLES);
        winner <= 2'd2;
        run_cycles(LOOP_CYCLES);
        winner <= 2'd0;
        run_cycles(int'(LINE_LAST) + 1);
        winner <= 2'd3;                    // Another blank code mid loop
        run_cycles(LOOP_CYCLES - int'(LINE_LAST) - 1 + 8);
        total_errors = led_errors + seg_errors + lcd_errors + other_errors;
        $display("Errors: leds %0d, seg %0d, lcd %0d, other %0d, total %0d",
                 led_errors, seg_errors, lcd_errors, other_errors, total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the stimulus did not finish", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
